//--- design/exec_params.svh
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// data word width
`define EXEC_XLEN 32

// multiplier busy cycles before its done cycle
`define EXEC_MUL_CYCLES 3

// restoring divider iterations with one quotient bit each
`define EXEC_DIV_CYCLES 32

// JAL writes pc plus this
`define EXEC_LINK_OFFSET 8

`endif

//--- design/exec_pkg.sv
`include "exec_params.svh"

package exec_pkg;

    // decoded opcodes seen by the execute stage
    typedef enum logic [4:0] {
        OP_NOP   = 5'd0,
        // alu
        OP_ADD   = 5'd1,
        OP_ADDU  = 5'd2,
        OP_SUB   = 5'd3,
        OP_SUBU  = 5'd4,
        OP_AND   = 5'd5,
        OP_OR    = 5'd6,
        OP_XOR   = 5'd7,
        OP_NOR   = 5'd8,
        OP_SLT   = 5'd9,
        OP_SLTU  = 5'd10,
        OP_SLL   = 5'd11,
        OP_SRL   = 5'd12,
        OP_SRA   = 5'd13,
        OP_LUI   = 5'd14,
        // multiply and divide write hi/lo
        OP_MULT  = 5'd15,
        OP_MULTU = 5'd16,
        OP_DIV   = 5'd17,
        OP_DIVU  = 5'd18,
        // control transfer in slot 1 only
        OP_BEQ   = 5'd19,
        OP_BNE   = 5'd20,
        OP_BLEZ  = 5'd21,
        OP_BGTZ  = 5'd22,
        OP_J     = 5'd23,
        OP_JAL   = 5'd24,
        OP_JR    = 5'd25
    } exec_op_e;

    // shared multiply/divide unit
    typedef enum logic [1:0] {
        MD_IDLE = 2'd0,
        MD_MUL  = 2'd1,
        MD_DIV  = 2'd2,
        MD_DONE = 2'd3
    } muldiv_state_e;

    // one slot's output
    typedef struct packed {
        logic                  valid;
        logic                  overflow;
        logic [`EXEC_XLEN-1:0] result;
    } slot_result_t;

endpackage

//--- design/exec_slot_if.sv
`timescale 1ns/100ps
`include "exec_params.svh"

// one issue slot after decode and register read
interface exec_slot_if;
    logic                  valid;
    exec_pkg::exec_op_e    op;
    logic [`EXEC_XLEN-1:0] rs_val;
    logic [`EXEC_XLEN-1:0] rt_val;
    logic [`EXEC_XLEN-1:0] instr;
    logic [`EXEC_XLEN-1:0] pc;
    logic                  use_imm;

    modport producer (
        output valid, op, rs_val, rt_val, instr, pc, use_imm
    );

    modport consumer (
        input valid, op, rs_val, rt_val, instr, pc, use_imm
    );
endinterface

//--- design/operand_select.sv
`timescale 1ns/100ps
`include "exec_params.svh"

module operand_select (
    exec_slot_if.consumer         slot_i,
    output logic [`EXEC_XLEN-1:0] op_a_o,
    output logic [`EXEC_XLEN-1:0] op_b_o
);
    logic [15:0]           imm;
    logic [`EXEC_XLEN-1:0] imm_ext;
    logic                  is_shift;

    assign imm = slot_i.instr[15:0];

    assign is_shift = (slot_i.op == exec_pkg::OP_SLL) ||
                      (slot_i.op == exec_pkg::OP_SRL) ||
                      (slot_i.op == exec_pkg::OP_SRA);

    // logical ops zero-extend and the rest sign-extend
    always_comb begin
        case (slot_i.op)
            exec_pkg::OP_AND, exec_pkg::OP_OR, exec_pkg::OP_XOR: begin
                imm_ext = {{(`EXEC_XLEN-16){1'b0}}, imm};
            end
            exec_pkg::OP_LUI: begin
                imm_ext = {{(`EXEC_XLEN-16){1'b0}}, imm} << 16;
            end
            default: begin
                imm_ext = {{(`EXEC_XLEN-16){imm[15]}}, imm};
            end
        endcase
    end

    always_comb begin
        if (is_shift) begin
            // shifts act on rt, amount from the shamt field
            op_a_o = slot_i.rt_val;
            op_b_o = {{(`EXEC_XLEN-5){1'b0}}, slot_i.instr[10:6]};
        end else begin
            op_a_o = slot_i.rs_val;
            op_b_o = slot_i.use_imm ? imm_ext : slot_i.rt_val;
        end
    end

endmodule

//--- design/alu.sv
`timescale 1ns/100ps
`include "exec_params.svh"

module alu (
    input  exec_pkg::exec_op_e    op_i,
    input  logic [`EXEC_XLEN-1:0] op_a_i,
    input  logic [`EXEC_XLEN-1:0] op_b_i,
    output logic [`EXEC_XLEN-1:0] result_o,
    output logic                  overflow_o
);
    localparam int MSB = `EXEC_XLEN - 1;
    localparam int SHW = $clog2(`EXEC_XLEN);

    logic [`EXEC_XLEN-1:0] sum;
    logic [`EXEC_XLEN-1:0] diff;
    logic [SHW-1:0]        shamt;

    assign sum   = op_a_i + op_b_i;
    assign diff  = op_a_i - op_b_i;
    assign shamt = op_b_i[SHW-1:0];

    always_comb begin
        result_o   = '0;
        overflow_o = 1'b0;
        case (op_i)
            exec_pkg::OP_ADD: begin
                result_o = sum;
                // same-sign operands with a flipped result sign
                overflow_o = (op_a_i[MSB] == op_b_i[MSB]) && (sum[MSB] != op_a_i[MSB]);
            end
            exec_pkg::OP_SUB: begin
                result_o = diff;
                overflow_o = (op_a_i[MSB] != op_b_i[MSB]) && (diff[MSB] != op_a_i[MSB]);
            end
            exec_pkg::OP_ADDU: result_o = sum;
            exec_pkg::OP_SUBU: result_o = diff;
            exec_pkg::OP_AND:  result_o = op_a_i & op_b_i;
            exec_pkg::OP_OR:   result_o = op_a_i | op_b_i;
            exec_pkg::OP_XOR:  result_o = op_a_i ^ op_b_i;
            exec_pkg::OP_NOR:  result_o = ~(op_a_i | op_b_i);
            exec_pkg::OP_SLT: begin
                result_o = {{MSB{1'b0}}, ($signed(op_a_i) < $signed(op_b_i))};
            end
            exec_pkg::OP_SLTU: begin
                result_o = {{MSB{1'b0}}, (op_a_i < op_b_i)};
            end
            exec_pkg::OP_SLL: result_o = op_a_i << shamt;
            exec_pkg::OP_SRL: result_o = op_a_i >> shamt;
            exec_pkg::OP_SRA: result_o = $signed(op_a_i) >>> shamt;
            // immediate already sits in the upper half
            exec_pkg::OP_LUI: result_o = op_b_i;
            default: begin
                result_o   = '0;
                overflow_o = 1'b0;
            end
        endcase
    end

endmodule

//--- design/branch_resolve.sv
`timescale 1ns/100ps
`include "exec_params.svh"

module branch_resolve (
    exec_slot_if.consumer         slot_i,
    output logic                  branch_taken_o,
    output logic [`EXEC_XLEN-1:0] target_o
);
    logic [`EXEC_XLEN-1:0] pc_plus4;
    logic [`EXEC_XLEN-1:0] br_offset;
    logic [`EXEC_XLEN-1:0] br_target;
    logic [`EXEC_XLEN-1:0] jmp_target;
    logic                  rs_le_zero;
    logic                  cond;

    assign pc_plus4  = slot_i.pc + `EXEC_XLEN'(4);
    assign br_offset = {{(`EXEC_XLEN-18){slot_i.instr[15]}}, slot_i.instr[15:0], 2'b00};
    assign br_target = pc_plus4 + br_offset;

    // region bits of pc+4 followed by the 26-bit index
    assign jmp_target = {pc_plus4[`EXEC_XLEN-1:28], slot_i.instr[25:0], 2'b00};

    assign rs_le_zero = slot_i.rs_val[`EXEC_XLEN-1] || (slot_i.rs_val == '0);

    always_comb begin
        cond     = 1'b0;
        target_o = '0;
        case (slot_i.op)
            exec_pkg::OP_BEQ: begin
                cond     = (slot_i.rs_val == slot_i.rt_val);
                target_o = br_target;
            end
            exec_pkg::OP_BNE: begin
                cond     = (slot_i.rs_val != slot_i.rt_val);
                target_o = br_target;
            end
            exec_pkg::OP_BLEZ: begin
                cond     = rs_le_zero;
                target_o = br_target;
            end
            exec_pkg::OP_BGTZ: begin
                cond     = !rs_le_zero;
                target_o = br_target;
            end
            exec_pkg::OP_J, exec_pkg::OP_JAL: begin
                cond     = 1'b1;
                target_o = jmp_target;
            end
            exec_pkg::OP_JR: begin
                cond     = 1'b1;
                target_o = slot_i.rs_val;
            end
            default: ;
        endcase
    end

    assign branch_taken_o = slot_i.valid && cond;

endmodule

//--- design/muldiv_unit.sv
`timescale 1ns/100ps
`include "exec_params.svh"

module muldiv_unit (
    input  logic                      clk,
    input  logic                      rst_n_i,
    exec_slot_if.consumer             slot1_i,
    exec_slot_if.consumer             slot0_i,
    output logic                      stall_o,
    output logic [2*`EXEC_XLEN-1:0]   hilo_o,
    output logic                      hilo_valid_o
);
    localparam int XLEN  = `EXEC_XLEN;
    localparam int CNT_W = $clog2(`EXEC_DIV_CYCLES + 1);

    exec_pkg::muldiv_state_e state_q;
    exec_pkg::exec_op_e      sel_op;

    logic [CNT_W-1:0]  cnt_q;
    logic              pick1;
    logic              req;
    logic              sel_signed;
    logic              sel_is_div;
    logic [XLEN-1:0]   sel_a;
    logic [XLEN-1:0]   sel_b;
    logic              neg_a;
    logic              neg_b;
    logic [XLEN-1:0]   mag_a;
    logic [XLEN-1:0]   mag_b;
    logic [XLEN-1:0]   a_q;
    logic [XLEN-1:0]   b_q;
    logic              neg_a_q;
    logic              neg_b_q;
    logic              is_div_q;
    logic [2*XLEN-1:0] acc_q;
    logic [XLEN:0]     shifted;
    logic [XLEN:0]     trial;
    logic [XLEN-1:0]   quo_fix;
    logic [XLEN-1:0]   rem_fix;
    logic [2*XLEN-1:0] prod_fix;

    function automatic logic is_muldiv(input exec_pkg::exec_op_e op);
        return op inside {exec_pkg::OP_MULT, exec_pkg::OP_MULTU,
                          exec_pkg::OP_DIV, exec_pkg::OP_DIVU};
    endfunction

    // older slot wins the unit
    assign pick1 = slot1_i.valid && is_muldiv(slot1_i.op);
    assign req   = pick1 || (slot0_i.valid && is_muldiv(slot0_i.op));

    assign sel_op = pick1 ? slot1_i.op : slot0_i.op;
    assign sel_a  = pick1 ? slot1_i.rs_val : slot0_i.rs_val;
    assign sel_b  = pick1 ? slot1_i.rt_val : slot0_i.rt_val;

    assign sel_signed = (sel_op == exec_pkg::OP_MULT) || (sel_op == exec_pkg::OP_DIV);
    assign sel_is_div = (sel_op == exec_pkg::OP_DIV) || (sel_op == exec_pkg::OP_DIVU);
    assign neg_a      = sel_signed && sel_a[XLEN-1];
    assign neg_b      = sel_signed && sel_b[XLEN-1];
    assign mag_a      = neg_a ? -sel_a : sel_a;
    assign mag_b      = neg_b ? -sel_b : sel_b;

    // acc keeps the partial remainder above the dividend bits that turn into quotient bits
    assign shifted = {acc_q[2*XLEN-1:XLEN], acc_q[XLEN-1]};
    assign trial   = shifted - {1'b0, b_q};

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= exec_pkg::MD_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                exec_pkg::MD_IDLE: begin
                    cnt_q <= '0;
                    if (req && sel_is_div) begin
                        state_q <= exec_pkg::MD_DIV;
                    end else if (req) begin
                        state_q <= exec_pkg::MD_MUL;
                    end
                end
                exec_pkg::MD_MUL: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(`EXEC_MUL_CYCLES - 2)) begin
                        state_q <= exec_pkg::MD_DONE;
                    end
                end
                exec_pkg::MD_DIV: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(`EXEC_DIV_CYCLES - 1)) begin
                        state_q <= exec_pkg::MD_DONE;
                    end
                end
                default: state_q <= exec_pkg::MD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            exec_pkg::MD_IDLE: begin
                if (req) begin
                    a_q      <= mag_a;
                    b_q      <= mag_b;
                    neg_a_q  <= neg_a;
                    neg_b_q  <= neg_b;
                    is_div_q <= sel_is_div;
                    acc_q    <= {{XLEN{1'b0}}, mag_a};
                end
            end
            exec_pkg::MD_MUL: acc_q <= a_q * b_q;
            exec_pkg::MD_DIV: begin
                if (!trial[XLEN]) begin
                    acc_q <= {trial[XLEN-1:0], acc_q[XLEN-2:0], 1'b1};
                end else begin
                    acc_q <= {shifted[XLEN-1:0], acc_q[XLEN-2:0], 1'b0};
                end
            end
            default: ;
        endcase
    end

    // remainder takes the sign of the dividend
    assign prod_fix = (neg_a_q ^ neg_b_q) ? -acc_q : acc_q;
    assign quo_fix  = (neg_a_q ^ neg_b_q) ? -acc_q[XLEN-1:0] : acc_q[XLEN-1:0];
    assign rem_fix  = neg_a_q ? -acc_q[2*XLEN-1:XLEN] : acc_q[2*XLEN-1:XLEN];

    assign hilo_o       = is_div_q ? {rem_fix, quo_fix} : prod_fix;
    assign hilo_valid_o = (state_q == exec_pkg::MD_DONE);
    assign stall_o      = ((state_q == exec_pkg::MD_IDLE) && req) ||
                          (state_q == exec_pkg::MD_MUL) ||
                          (state_q == exec_pkg::MD_DIV);

endmodule

//--- design/result_merge.sv
`timescale 1ns/100ps
`include "exec_params.svh"

module result_merge (
    exec_slot_if.consumer          slot1_i,
    input  logic                   slot0_valid_i,
    input  logic [`EXEC_XLEN-1:0]  alu1_result_i,
    input  logic [`EXEC_XLEN-1:0]  alu0_result_i,
    input  logic                   alu1_overflow_i,
    input  logic                   alu0_overflow_i,
    output exec_pkg::slot_result_t slot1_o,
    output exec_pkg::slot_result_t slot0_o
);
    logic [`EXEC_XLEN-1:0] link_val;
    logic                  ovf1;
    logic                  valid0;

    assign link_val = slot1_i.pc + `EXEC_XLEN'(`EXEC_LINK_OFFSET);
    assign ovf1     = slot1_i.valid && alu1_overflow_i;

    // an overflowing older instruction kills the younger one
    assign valid0 = slot0_valid_i && !ovf1;

    always_comb begin
        slot1_o.valid    = slot1_i.valid;
        slot1_o.overflow = ovf1;
        if (slot1_i.op == exec_pkg::OP_JAL) begin
            slot1_o.result = link_val;
        end else begin
            slot1_o.result = alu1_result_i;
        end

        slot0_o.valid    = valid0;
        slot0_o.overflow = valid0 && alu0_overflow_i;
        slot0_o.result   = alu0_result_i;
    end

endmodule

//--- design/execute_top.sv
`timescale 1ns/100ps
`include "exec_params.svh"

module execute_top (
    input  logic                      clk,
    input  logic                      rst_n_i,
    // older slot 1
    input  logic                      s1_valid_i,
    input  exec_pkg::exec_op_e        s1_op_i,
    input  logic [`EXEC_XLEN-1:0]     s1_rs_val_i,
    input  logic [`EXEC_XLEN-1:0]     s1_rt_val_i,
    input  logic [`EXEC_XLEN-1:0]     s1_instr_i,
    input  logic [`EXEC_XLEN-1:0]     s1_pc_i,
    input  logic                      s1_use_imm_i,
    // younger slot 0
    input  logic                      s0_valid_i,
    input  exec_pkg::exec_op_e        s0_op_i,
    input  logic [`EXEC_XLEN-1:0]     s0_rs_val_i,
    input  logic [`EXEC_XLEN-1:0]     s0_rt_val_i,
    input  logic [`EXEC_XLEN-1:0]     s0_instr_i,
    input  logic [`EXEC_XLEN-1:0]     s0_pc_i,
    input  logic                      s0_use_imm_i,
    output logic                      s1_valid_o,
    output logic [`EXEC_XLEN-1:0]     s1_result_o,
    output logic                      s1_overflow_o,
    output logic                      s0_valid_o,
    output logic [`EXEC_XLEN-1:0]     s0_result_o,
    output logic                      s0_overflow_o,
    output logic                      branch_taken_o,
    output logic [`EXEC_XLEN-1:0]     target_o,
    output logic [2*`EXEC_XLEN-1:0]   hilo_o,
    output logic                      hilo_valid_o,
    output logic                      stall_o
);
    exec_slot_if slot1 ();
    exec_slot_if slot0 ();

    logic [`EXEC_XLEN-1:0]  op_a1;
    logic [`EXEC_XLEN-1:0]  op_b1;
    logic [`EXEC_XLEN-1:0]  op_a0;
    logic [`EXEC_XLEN-1:0]  op_b0;
    logic [`EXEC_XLEN-1:0]  alu1_result;
    logic [`EXEC_XLEN-1:0]  alu0_result;
    logic                   alu1_overflow;
    logic                   alu0_overflow;
    exec_pkg::slot_result_t res1;
    exec_pkg::slot_result_t res0;

    assign slot1.valid   = s1_valid_i;
    assign slot1.op      = s1_op_i;
    assign slot1.rs_val  = s1_rs_val_i;
    assign slot1.rt_val  = s1_rt_val_i;
    assign slot1.instr   = s1_instr_i;
    assign slot1.pc      = s1_pc_i;
    assign slot1.use_imm = s1_use_imm_i;

    assign slot0.valid   = s0_valid_i;
    assign slot0.op      = s0_op_i;
    assign slot0.rs_val  = s0_rs_val_i;
    assign slot0.rt_val  = s0_rt_val_i;
    assign slot0.instr   = s0_instr_i;
    assign slot0.pc      = s0_pc_i;
    assign slot0.use_imm = s0_use_imm_i;

    operand_select u_opsel1 (.slot_i(slot1), .op_a_o(op_a1), .op_b_o(op_b1));
    operand_select u_opsel0 (.slot_i(slot0), .op_a_o(op_a0), .op_b_o(op_b0));

    alu u_alu1 (
        .op_i       (s1_op_i),
        .op_a_i     (op_a1),
        .op_b_i     (op_b1),
        .result_o   (alu1_result),
        .overflow_o (alu1_overflow)
    );

    alu u_alu0 (
        .op_i       (s0_op_i),
        .op_a_i     (op_a0),
        .op_b_i     (op_b0),
        .result_o   (alu0_result),
        .overflow_o (alu0_overflow)
    );

    // only the older slot may redirect fetch
    branch_resolve u_branch (
        .slot_i         (slot1),
        .branch_taken_o (branch_taken_o),
        .target_o       (target_o)
    );

    muldiv_unit u_muldiv (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .slot1_i      (slot1),
        .slot0_i      (slot0),
        .stall_o      (stall_o),
        .hilo_o       (hilo_o),
        .hilo_valid_o (hilo_valid_o)
    );

    result_merge u_merge (
        .slot1_i         (slot1),
        .slot0_valid_i   (s0_valid_i),
        .alu1_result_i   (alu1_result),
        .alu0_result_i   (alu0_result),
        .alu1_overflow_i (alu1_overflow),
        .alu0_overflow_i (alu0_overflow),
        .slot1_o         (res1),
        .slot0_o         (res0)
    );

    assign s1_valid_o    = res1.valid;
    assign s1_result_o   = res1.result;
    assign s1_overflow_o = res1.overflow;
    assign s0_valid_o    = res0.valid;
    assign s0_result_o   = res0.result;
    assign s0_overflow_o = res0.overflow;

endmodule

//--- sim/execute_tb.sv
`timescale 1ns/100ps
`include "exec_params.svh"

module execute_tb;
    typedef logic [`EXEC_XLEN-1:0]   word_t;
    typedef logic [2*`EXEC_XLEN-1:0] dword_t;

    typedef struct {
        logic               valid;
        exec_pkg::exec_op_e op;
        word_t              rs_val;
        word_t              rt_val;
        word_t              instr;
        word_t              pc;
        logic               use_imm;
    } slot_in_t;

    typedef struct {
        string                  name;
        slot_in_t               s1;
        slot_in_t               s0;
        exec_pkg::slot_result_t exp1;
        exec_pkg::slot_result_t exp0;
        logic                   taken;
        word_t                  target;
        logic                   muldiv;
        dword_t                 hilo;
    } test_t;

    logic               clk;
    logic               rst_n;
    logic               s1_valid;
    logic               s1_use_imm;
    logic               s0_valid;
    logic               s0_use_imm;
    exec_pkg::exec_op_e s1_op;
    exec_pkg::exec_op_e s0_op;
    word_t              s1_rs_val;
    word_t              s1_rt_val;
    word_t              s1_instr;
    word_t              s1_pc;
    word_t              s0_rs_val;
    word_t              s0_rt_val;
    word_t              s0_instr;
    word_t              s0_pc;
    logic               s1_valid_o;
    logic               s1_overflow_o;
    logic               s0_valid_o;
    logic               s0_overflow_o;
    word_t              s1_result_o;
    word_t              s0_result_o;
    word_t              target;
    logic               branch_taken;
    logic               hilo_valid;
    logic               stall;
    dword_t             hilo;

    test_t       tests[$];
    int          errors = 0;
    int unsigned cycles = 0;
    int unsigned limit = 0;

    execute_top DUT (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .s1_valid_i     (s1_valid),
        .s1_op_i        (s1_op),
        .s1_rs_val_i    (s1_rs_val),
        .s1_rt_val_i    (s1_rt_val),
        .s1_instr_i     (s1_instr),
        .s1_pc_i        (s1_pc),
        .s1_use_imm_i   (s1_use_imm),
        .s0_valid_i     (s0_valid),
        .s0_op_i        (s0_op),
        .s0_rs_val_i    (s0_rs_val),
        .s0_rt_val_i    (s0_rt_val),
        .s0_instr_i     (s0_instr),
        .s0_pc_i        (s0_pc),
        .s0_use_imm_i   (s0_use_imm),
        .s1_valid_o     (s1_valid_o),
        .s1_result_o    (s1_result_o),
        .s1_overflow_o  (s1_overflow_o),
        .s0_valid_o     (s0_valid_o),
        .s0_result_o    (s0_result_o),
        .s0_overflow_o  (s0_overflow_o),
        .branch_taken_o (branch_taken),
        .target_o       (target),
        .hilo_o         (hilo),
        .hilo_valid_o   (hilo_valid),
        .stall_o        (stall)
    );

    always #4 clk = ~clk;

    // run length guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout: run passed %0d cycles with %0d errors", limit, errors);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic slot_in_t make_slot(input logic v, input exec_pkg::exec_op_e op,
            input word_t rs, input word_t rt, input word_t instr, input word_t pc,
            input logic imm);
        slot_in_t s;
        s.valid   = v;
        s.op      = op;
        s.rs_val  = rs;
        s.rt_val  = rt;
        s.instr   = instr;
        s.pc      = pc;
        s.use_imm = imm;
        return s;
    endfunction

    function automatic exec_pkg::slot_result_t make_res(input logic v, input logic o,
            input word_t r);
        return '{valid: v, overflow: o, result: r};
    endfunction

    task automatic add_test(input string name, input slot_in_t s1, input slot_in_t s0,
            input exec_pkg::slot_result_t e1, input exec_pkg::slot_result_t e0,
            input logic taken, input word_t tgt, input logic md, input dword_t hl);
        test_t t;
        t.name   = name;
        t.s1     = s1;
        t.s0     = s0;
        t.exp1   = e1;
        t.exp0   = e0;
        t.taken  = taken;
        t.target = tgt;
        t.muldiv = md;
        t.hilo   = hl;
        tests.push_back(t);
    endtask

    task automatic check_word(input string test, input string what, input word_t exp,
            input word_t act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", test, what, exp, act);
        end
    endtask

    task automatic check_bit(input string test, input string what, input logic exp,
            input logic act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s %s: expected %b, actual %b", test, what, exp, act);
        end
    endtask

    task automatic check_op_result(input string test, input string what,
            input exec_pkg::slot_result_t exp, input exec_pkg::slot_result_t act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s %s: expected v=%b ovf=%b res=%h, actual v=%b ovf=%b res=%h",
                     test, what, exp.valid, exp.overflow, exp.result,
                     act.valid, act.overflow, act.result);
        end
    endtask

    task automatic check_hilo(input string test, input dword_t exp, input dword_t act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s hilo: expected %h, actual %h", test, exp, act);
        end
    endtask

    task automatic drive_inputs(input test_t t);
        s1_valid   <= t.s1.valid;
        s1_op      <= t.s1.op;
        s1_rs_val  <= t.s1.rs_val;
        s1_rt_val  <= t.s1.rt_val;
        s1_instr   <= t.s1.instr;
        s1_pc      <= t.s1.pc;
        s1_use_imm <= t.s1.use_imm;
        s0_valid   <= t.s0.valid;
        s0_op      <= t.s0.op;
        s0_rs_val  <= t.s0.rs_val;
        s0_rt_val  <= t.s0.rt_val;
        s0_instr   <= t.s0.instr;
        s0_pc      <= t.s0.pc;
        s0_use_imm <= t.s0.use_imm;
    endtask

    task automatic check_outputs(input test_t t, input logic saw_stall);
        exec_pkg::slot_result_t act1;
        exec_pkg::slot_result_t act0;
        act1 = {s1_valid_o, s1_overflow_o, s1_result_o};
        act0 = {s0_valid_o, s0_overflow_o, s0_result_o};
        check_op_result(t.name, "slot1", t.exp1, act1);
        check_op_result(t.name, "slot0", t.exp0, act0);
        check_bit(t.name, "branch_taken", t.taken, branch_taken);
        check_word(t.name, "target", t.target, target);
        check_bit(t.name, "stall_seen", t.muldiv, saw_stall);
        check_bit(t.name, "hilo_valid", t.muldiv, hilo_valid);
        if (t.muldiv) begin
            check_hilo(t.name, t.hilo, hilo);
        end
    endtask

    task automatic build_table();
        slot_in_t               nop;
        exec_pkg::slot_result_t none;
        word_t                  a;
        word_t                  b;
        word_t                  c;
        word_t                  d;
        nop  = make_slot(0, exec_pkg::OP_NOP, '0, '0, '0, '0, 0);
        none = make_res(0, 0, '0);
        add_test("add_imm_sext",
            make_slot(1, exec_pkg::OP_ADD, 32'd100, 32'd0, 32'h0000_fff6, 32'd0, 1),
            make_slot(1, exec_pkg::OP_ADDU, 32'd5, 32'd7, 32'd0, 32'd0, 0),
            make_res(1, 0, 32'd90), make_res(1, 0, 32'd12), 0, '0, 0, '0);
        add_test("logic_imm_zext",
            make_slot(1, exec_pkg::OP_OR, 32'h1234_0000, 32'd0, 32'h0000_8001, 32'd0, 1),
            make_slot(1, exec_pkg::OP_XOR, 32'hffff_0000, 32'd0, 32'h0000_ffff, 32'd0, 1),
            make_res(1, 0, 32'h1234_8001), make_res(1, 0, 32'hffff_ffff), 0, '0, 0, '0);
        add_test("lui_sll",
            make_slot(1, exec_pkg::OP_LUI, 32'd0, 32'd0, 32'h0000_abcd, 32'd0, 1),
            make_slot(1, exec_pkg::OP_SLL, 32'd0, 32'd3, 32'h0000_0100, 32'd0, 0),
            make_res(1, 0, 32'habcd_0000), make_res(1, 0, 32'h30), 0, '0, 0, '0);
        add_test("sra_srl",
            make_slot(1, exec_pkg::OP_SRA, 32'd0, 32'h8000_0010, 32'h0000_0100, 32'd0, 0),
            make_slot(1, exec_pkg::OP_SRL, 32'd0, 32'h8000_0010, 32'h0000_0100, 32'd0, 0),
            make_res(1, 0, 32'hf800_0001), make_res(1, 0, 32'h0800_0001), 0, '0, 0, '0);
        add_test("slt_sub",
            make_slot(1, exec_pkg::OP_SLT, 32'hffff_ffff, 32'd1, 32'd0, 32'd0, 0),
            make_slot(1, exec_pkg::OP_SUB, 32'd5, 32'd7, 32'd0, 32'd0, 0),
            make_res(1, 0, 32'd1), make_res(1, 0, 32'hffff_fffe), 0, '0, 0, '0);
        // older overflow squashes the younger slot
        add_test("ovf_slot1",
            make_slot(1, exec_pkg::OP_ADD, 32'h7fff_ffff, 32'd1, 32'd0, 32'd0, 0),
            make_slot(1, exec_pkg::OP_ADDU, 32'd1, 32'd2, 32'd0, 32'd0, 0),
            make_res(1, 1, 32'h8000_0000), make_res(0, 0, 32'd3), 0, '0, 0, '0);
        add_test("ovf_slot0",
            make_slot(1, exec_pkg::OP_ADDU, 32'h7fff_ffff, 32'd1, 32'd0, 32'd0, 0),
            make_slot(1, exec_pkg::OP_SUB, 32'h8000_0000, 32'd1, 32'd0, 32'd0, 0),
            make_res(1, 0, 32'h8000_0000), make_res(1, 1, 32'h7fff_ffff), 0, '0, 0, '0);
        // branch target is pc+4 plus offset*4
        add_test("beq_taken",
            make_slot(1, exec_pkg::OP_BEQ, 32'd5, 32'd5, 32'h0000_0010, 32'h0040_0000, 0),
            make_slot(1, exec_pkg::OP_NOR, 32'h0f0f_0000, 32'h0000_00f0, 32'd0, 32'd0, 0),
            make_res(1, 0, '0), make_res(1, 0, 32'hf0f0_ff0f), 1, 32'h0040_0044, 0, '0);
        add_test("beq_not_taken",
            make_slot(1, exec_pkg::OP_BEQ, 32'd5, 32'd6, 32'h0000_0010, 32'h0040_0000, 0),
            make_slot(1, exec_pkg::OP_AND, 32'hff00_ff00, 32'h0ff0_0ff0, 32'd0, 32'd0, 0),
            make_res(1, 0, '0), make_res(1, 0, 32'h0f00_0f00), 0, 32'h0040_0044, 0, '0);
        add_test("bne_taken",
            make_slot(1, exec_pkg::OP_BNE, 32'd5, 32'd6, 32'h0000_fffc, 32'h0040_0100, 0),
            make_slot(1, exec_pkg::OP_SUBU, 32'd0, 32'd1, 32'd0, 32'd0, 0),
            make_res(1, 0, '0), make_res(1, 0, 32'hffff_ffff), 1, 32'h0040_00f4, 0, '0);
        add_test("bne_not_taken",
            make_slot(1, exec_pkg::OP_BNE, 32'd5, 32'd5, 32'h0000_fffc, 32'h0040_0100, 0),
            make_slot(1, exec_pkg::OP_SLTU, 32'hffff_ffff, 32'd1, 32'd0, 32'd0, 0),
            make_res(1, 0, '0), make_res(1, 0, 32'd0), 0, 32'h0040_00f4, 0, '0);
        add_test("blez_taken",
            make_slot(1, exec_pkg::OP_BLEZ, 32'd0, 32'd0, 32'h0000_0001, 32'h0000_1000, 0),
            nop, make_res(1, 0, '0), none, 1, 32'h0000_1008, 0, '0);
        add_test("blez_not_taken",
            make_slot(1, exec_pkg::OP_BLEZ, 32'd1, 32'd0, 32'h0000_0001, 32'h0000_1000, 0),
            nop, make_res(1, 0, '0), none, 0, 32'h0000_1008, 0, '0);
        add_test("bgtz_taken",
            make_slot(1, exec_pkg::OP_BGTZ, 32'd1, 32'd0, 32'h0000_0002, 32'h0000_2000, 0),
            nop, make_res(1, 0, '0), none, 1, 32'h0000_200c, 0, '0);
        add_test("bgtz_not_taken",
            make_slot(1, exec_pkg::OP_BGTZ, 32'h8000_0000, 32'd0, 32'h2, 32'h0000_2000, 0),
            nop, make_res(1, 0, '0), none, 0, 32'h0000_200c, 0, '0);
        // region bits come from pc+4
        add_test("j",
            make_slot(1, exec_pkg::OP_J, 32'd0, 32'd0, 32'h0812_3456, 32'h3fff_fffc, 0),
            nop, make_res(1, 0, '0), none, 1, 32'h4048_d158, 0, '0);
        add_test("jal",
            make_slot(1, exec_pkg::OP_JAL, 32'd0, 32'd0, 32'h0c10_0010, 32'h0040_0020, 0),
            nop, make_res(1, 0, 32'h0040_0028), none, 1, 32'h0040_0040, 0, '0);
        add_test("jr",
            make_slot(1, exec_pkg::OP_JR, 32'h0040_1234, 32'd0, 32'd0, 32'd0, 0),
            nop, make_res(1, 0, '0), none, 1, 32'h0040_1234, 0, '0);
        add_test("mult_mixed",
            make_slot(1, exec_pkg::OP_MULT, 32'hffff_fffd, 32'd7, 32'd0, 32'd0, 0),
            nop, make_res(1, 0, '0), none, 0, '0, 1, 64'hffff_ffff_ffff_ffeb);
        add_test("multu_slot0", nop,
            make_slot(1, exec_pkg::OP_MULTU, 32'hffff_ffff, 32'd2, 32'd0, 32'd0, 0),
            none, make_res(1, 0, '0), 0, '0, 1, 64'h0000_0001_ffff_fffe);
        // hi holds the remainder and lo the quotient
        add_test("div_neg_dividend",
            make_slot(1, exec_pkg::OP_DIV, 32'hffff_fff9, 32'd2, 32'd0, 32'd0, 0),
            nop, make_res(1, 0, '0), none, 0, '0, 1, 64'hffff_ffff_ffff_fffd);
        add_test("div_neg_divisor",
            make_slot(1, exec_pkg::OP_DIV, 32'd7, 32'hffff_fffe, 32'd0, 32'd0, 0),
            nop, make_res(1, 0, '0), none, 0, '0, 1, 64'h0000_0001_ffff_fffd);
        add_test("divu",
            make_slot(1, exec_pkg::OP_DIVU, 32'hffff_fff9, 32'd2, 32'd0, 32'd0, 0),
            nop, make_res(1, 0, '0), none, 0, '0, 1, 64'h0000_0001_7fff_fffc);
        add_test("div_by_zero",
            make_slot(1, exec_pkg::OP_DIV, 32'h0000_0055, 32'd0, 32'd0, 32'd0, 0),
            nop, make_res(1, 0, '0), none, 0, '0, 1, 64'h0000_0055_ffff_ffff);
        add_test("both_muldiv",
            make_slot(1, exec_pkg::OP_MULTU, 32'd3, 32'd5, 32'd0, 32'd0, 0),
            make_slot(1, exec_pkg::OP_DIVU, 32'd100, 32'd3, 32'd0, 32'd0, 0),
            make_res(1, 0, '0), make_res(1, 0, '0), 0, '0, 1, 64'h0000_0000_0000_000f);
        for (int i = 0; i < 8; i++) begin
            a = $urandom();
            b = $urandom();
            c = $urandom();
            d = $urandom();
            add_test($sformatf("rand_%0d", i),
                make_slot(1, exec_pkg::OP_ADDU, a, b, 32'd0, 32'd0, 0),
                make_slot(1, exec_pkg::OP_XOR, c, d, 32'd0, 32'd0, 0),
                make_res(1, 0, a + b), make_res(1, 0, c ^ d), 0, '0, 0, '0);
        end
    endtask

    initial begin
        logic saw_stall;
        clk = 1'b0;
        rst_n = 1'b0;
        drive_inputs('{name: "", s1: make_slot(0, exec_pkg::OP_NOP, '0, '0, '0, '0, 0),
                       s0: make_slot(0, exec_pkg::OP_NOP, '0, '0, '0, '0, 0),
                       exp1: '0, exp0: '0, taken: 0, target: '0, muldiv: 0, hilo: '0});
        void'($urandom(60));
        build_table();
        limit = 5 + tests.size() * (`EXEC_DIV_CYCLES + 4);
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        foreach (tests[i]) begin
            @(posedge clk);
            drive_inputs(tests[i]);
            @(negedge clk);
            saw_stall = stall;
            // inputs stay put while the unit is busy
            while (stall) begin
                @(negedge clk);
            end
            check_outputs(tests[i], saw_stall);
        end
        $display("%0d tests run, %0d errors", tests.size(), errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+design
design/exec_pkg.sv
design/exec_slot_if.sv
design/operand_select.sv
design/alu.sv
design/branch_resolve.sv
design/muldiv_unit.sv
design/result_merge.sv
design/execute_top.sv
sim/execute_tb.sv

//--- Bender.yml
package:
  name: dual_issue_execute

export_include_dirs:
  - design

sources:
  - files:
      - design/exec_pkg.sv
      - design/exec_slot_if.sv
      - design/operand_select.sv
      - design/alu.sv
      - design/branch_resolve.sv
      - design/muldiv_unit.sv
      - design/result_merge.sv
      - design/execute_top.sv
  - target: simulation
    files:
      - sim/execute_tb.sv
